// ==== verilog/gpr_pkg.sv ====
`default_nettype none

package gpr_pkg;

	// operand and register index widths
	localparam int gpr_data_w = 32;
	localparam int gpr_addr_w = 5;
	// number of architectural registers
	localparam int gpr_num_regs = 2 ** gpr_addr_w;

	// one operand word
	typedef logic [gpr_data_w-1:0] gpr_data_t;

	// one register index
	typedef logic [gpr_addr_w-1:0] gpr_addr_t;

	// read request of one operand port, 6 bits
	typedef struct packed {
		logic en;
		gpr_addr_t addr;
	} gpr_rd_req_t;

	// one write, 38 bits
	// used for both write-back sources and the merged port
	typedef struct packed {
		logic en;
		gpr_addr_t addr;
		gpr_data_t data;
	} gpr_wr_t;

endpackage

`default_nettype wire

// ==== verilog/gpr_wb_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module gpr_wb_arbiter
	import gpr_pkg::*;
(
	// write-back source a, higher priority
	input wire gpr_wr_t wb_a,
	// write-back source b, dropped when a is also writing
	input wire gpr_wr_t wb_b,
	// write-back stage stalled
	input wire wb_freeze,
	// pipeline flush
	input wire flushpipe,
	// merged write port toward the storage
	output gpr_wr_t wr_port
);

	// source chosen by priority
	gpr_wr_t sel;
	// write allowed by pipeline control
	logic wr_allow;

	// fixed priority
	// a wins whenever its enable is up
	// b only gets the port on a free cycle
	always_comb begin
		if (wb_a.en) begin
			sel = wb_a;
		end else begin
			sel = wb_b;
		end
	end

	// no commit while write-back is frozen
	// a flush also kills the write, the result belongs to a squashed op
	assign wr_allow = ~wb_freeze & ~flushpipe;

	// address and data straight from the winner
	// only the enable is qualified
	always_comb begin
		wr_port.en = sel.en & wr_allow;
		wr_port.addr = sel.addr;
		wr_port.data = sel.data;
	end

endmodule

`default_nettype wire

// ==== verilog/gpr_storage.sv ====
`timescale 1ns/10ps
`default_nettype none

module gpr_storage
	import gpr_pkg::*;
#(
	// register 0 hardwired to zero
	parameter bit zero_reg = 1'b1
) (
	input wire clk,
	input wire rst,
	// gated read requests
	input wire gpr_rd_req_t rd_a,
	input wire gpr_rd_req_t rd_b,
	input wire gpr_rd_req_t rd_c,
	// merged write port
	input wire gpr_wr_t wr_port,
	// registered read data
	output gpr_data_t raw_a,
	output gpr_data_t raw_b,
	output gpr_data_t raw_c
);

	// flop-based register array
	gpr_data_t regs [gpr_num_regs];
	// effective write strobe after the zero-register filter
	logic wr_en;
	// read ports as an array, index 0..2 is a, b, c
	gpr_rd_req_t rd_req [3];
	gpr_data_t raw [3];

	// read value of one index
	// r0 forced to zero when hardwired
	function automatic gpr_data_t read_word(input gpr_addr_t addr);
		if (zero_reg && addr == '0) begin
			return '0;
		end
		return regs[addr];
	endfunction

	// writes to r0 dropped when it is hardwired
	assign wr_en = wr_port.en && !(zero_reg && wr_port.addr == '0);

	// single write port
	// no bypass, a read at the same edge sees the old word
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < gpr_num_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_port.addr] <= wr_port.data;
		end
	end

	assign rd_req[0] = rd_a;
	assign rd_req[1] = rd_b;
	assign rd_req[2] = rd_c;

	// three registered read ports
	// output holds until the next enabled read
	for (genvar p = 0; p < 3; p++) begin : g_rd
		always_ff @(posedge clk or posedge rst) begin
			if (rst) begin
				raw[p] <= '0;
			end else if (rd_req[p].en) begin
				raw[p] <= read_word(rd_req[p].addr);
			end
		end
	end

	assign raw_a = raw[0];
	assign raw_b = raw[1];
	assign raw_c = raw[2];

	// write-back must present a clean index when it commits
	a_wr_addr_known: assert property (@(posedge clk) disable iff (rst)
		wr_port.en |-> !$isunknown(wr_port.addr))
		else $error("write with unknown address");

endmodule

`default_nettype wire

// ==== verilog/gpr_operand_hold.sv ====
`timescale 1ns/10ps
`default_nettype none

module gpr_operand_hold
	import gpr_pkg::*;
(
	input wire clk,
	input wire rst,
	// consuming stage frozen
	input wire freeze,
	// operand straight from the storage read port
	input wire gpr_data_t raw,
	// operand toward the consuming stage
	output gpr_data_t operand
);

	// held copy present
	logic valid;
	// copy of the operand taken at the first frozen edge
	gpr_data_t held;

	// control flag
	// set once on the first frozen edge
	// cleared on the first edge with the stage running again
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			valid <= 1'b0;
		end else if (freeze && !valid) begin
			valid <= 1'b1;
		end else if (!freeze) begin
			valid <= 1'b0;
		end
	end

	// capture only once per freeze
	// later raw changes must not leak into a stalled stage
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			held <= '0;
		end else if (freeze && !valid) begin
			held <= raw;
		end
	end

	// zero-cycle output path
	// copy while valid, live read data otherwise
	assign operand = valid ? held : raw;

endmodule

`default_nettype wire

// ==== verilog/gpr_file.sv ====
`timescale 1ns/10ps
`default_nettype none

module gpr_file
	import gpr_pkg::*;
#(
	// register 0 hardwired to zero
	parameter bit zero_reg = 1'b1
) (
	input wire clk,
	input wire rst,
	// pipeline control
	input wire id_freeze,
	input wire ex_freeze,
	input wire wb_freeze,
	input wire flushpipe,
	// write-back sources, a has priority
	input wire gpr_wr_t wb_a,
	input wire gpr_wr_t wb_b,
	// operand read requests from decode
	input wire gpr_rd_req_t rd_a,
	input wire gpr_rd_req_t rd_b,
	input wire gpr_rd_req_t rd_c,
	// operands toward execute
	output gpr_data_t data_a,
	output gpr_data_t data_b,
	output gpr_data_t data_c
);

	// read requests after the decode freeze gate
	gpr_rd_req_t rd_a_g;
	gpr_rd_req_t rd_b_g;
	gpr_rd_req_t rd_c_g;
	// merged write port
	gpr_wr_t wr_port;
	// registered read data before the hold stages
	gpr_data_t raw_a;
	gpr_data_t raw_b;
	gpr_data_t raw_c;

	// a stalled decode issues no new reads on any port
	// index passes through unchanged
	always_comb begin
		rd_a_g.en = rd_a.en & ~id_freeze;
		rd_a_g.addr = rd_a.addr;
		rd_b_g.en = rd_b.en & ~id_freeze;
		rd_b_g.addr = rd_b.addr;
		rd_c_g.en = rd_c.en & ~id_freeze;
		rd_c_g.addr = rd_c.addr;
	end

	// two write-back sources onto one port
	gpr_wb_arbiter i_wb_arbiter (
		.wb_a(wb_a),
		.wb_b(wb_b),
		.wb_freeze(wb_freeze),
		.flushpipe(flushpipe),
		.wr_port(wr_port)
	);

	// 3r1w flop array
	gpr_storage #(
		.zero_reg(zero_reg)
	) i_storage (
		.clk(clk),
		.rst(rst),
		.rd_a(rd_a_g),
		.rd_b(rd_b_g),
		.rd_c(rd_c_g),
		.wr_port(wr_port),
		.raw_a(raw_a),
		.raw_b(raw_b),
		.raw_c(raw_c)
	);

	// port a feeds decode-side logic, follows the decode freeze
	gpr_operand_hold hold_a (
		.clk(clk),
		.rst(rst),
		.freeze(id_freeze),
		.raw(raw_a),
		.operand(data_a)
	);

	// ports b and c are consumed in execute
	// a new read may land in storage while execute is still frozen
	gpr_operand_hold hold_b (
		.clk(clk),
		.rst(rst),
		.freeze(ex_freeze),
		.raw(raw_b),
		.operand(data_b)
	);

	gpr_operand_hold hold_c (
		.clk(clk),
		.rst(rst),
		.freeze(ex_freeze),
		.raw(raw_c),
		.operand(data_c)
	);

	// read gate and hold stage together keep operand a steady
	// across consecutive frozen edges
	a_data_a_stable: assert property (@(posedge clk) disable iff (rst)
		id_freeze && $past(id_freeze) |-> $stable(data_a))
		else $error("data_a changed during decode freeze");

endmodule

`default_nettype wire

// ==== test/gpr_tb_table.svh ====
// columns: behavior, freezes {id ex wb flush}, wb_a, wb_b, rd_a, rd_b, rd_c,
// check kind, expected data_a data_b data_c
localparam int n_dir = 16;

localparam row_t dir_rows [n_dir] = '{
	// write r3 from a, read at the same edge sees the old word
	'{3'd1, 4'b0000, '{1'b1, 5'd3, 32'h1003}, no_wr, '{1'b1, 5'd3}, no_rd, no_rd,
		chk_table, 32'h0, 32'h0, 32'h0},
	'{3'd1, 4'b0000, no_wr, no_wr, '{1'b1, 5'd3}, no_rd, no_rd,
		chk_table, 32'h1003, 32'h0, 32'h0},
	// both sources at once, only a lands
	'{3'd2, 4'b0000, '{1'b1, 5'd5, 32'h5005}, '{1'b1, 5'd6, 32'h6006}, no_rd, no_rd, no_rd,
		chk_model, 32'h0, 32'h0, 32'h0},
	'{3'd2, 4'b0000, no_wr, no_wr, no_rd, '{1'b1, 5'd5}, '{1'b1, 5'd6},
		chk_table, 32'h1003, 32'h5005, 32'h0},
	// write-back freeze, then flush
	'{3'd3, 4'b0010, '{1'b1, 5'd7, 32'h7007}, no_wr, no_rd, no_rd, no_rd,
		chk_none, 32'h0, 32'h0, 32'h0},
	'{3'd3, 4'b0001, no_wr, '{1'b1, 5'd7, 32'h7777}, no_rd, no_rd, no_rd,
		chk_none, 32'h0, 32'h0, 32'h0},
	'{3'd3, 4'b0000, no_wr, no_wr, '{1'b1, 5'd7}, '{1'b1, 5'd3}, no_rd,
		chk_table, 32'h0, 32'h1003, 32'h0},
	// decode freeze keeps data_a across an overwrite
	'{3'd4, 4'b0000, '{1'b1, 5'd8, 32'h8008}, no_wr, '{1'b1, 5'd3}, no_rd, no_rd,
		chk_model, 32'h0, 32'h0, 32'h0},
	// frozen reads on b and c are dropped, their raw words stay put
	'{3'd4, 4'b1000, no_wr, no_wr, '{1'b1, 5'd8}, '{1'b1, 5'd8}, '{1'b1, 5'd3},
		chk_table, 32'h1003, 32'h1003, 32'h0},
	'{3'd4, 4'b1000, '{1'b1, 5'd3, 32'h3333}, no_wr, '{1'b1, 5'd8}, no_rd, no_rd,
		chk_table, 32'h1003, 32'h1003, 32'h0},
	'{3'd4, 4'b0000, no_wr, no_wr, '{1'b1, 5'd3}, no_rd, no_rd,
		chk_table, 32'h3333, 32'h1003, 32'h0},
	// execute freeze holds b and c while storage reloads
	'{3'd5, 4'b0000, no_wr, no_wr, no_rd, '{1'b1, 5'd5}, '{1'b1, 5'd3},
		chk_model, 32'h0, 32'h0, 32'h0},
	'{3'd5, 4'b0100, no_wr, no_wr, no_rd, '{1'b1, 5'd8}, '{1'b1, 5'd5},
		chk_table, 32'h3333, 32'h5005, 32'h3333},
	'{3'd5, 4'b0100, '{1'b1, 5'd0, 32'hdead}, no_wr, no_rd, no_rd, no_rd,
		chk_table, 32'h3333, 32'h5005, 32'h3333},
	'{3'd5, 4'b0000, no_wr, no_wr, no_rd, no_rd, no_rd,
		chk_table, 32'h3333, 32'h8008, 32'h5005},
	'{3'd5, 4'b0000, no_wr, no_wr, '{1'b1, 5'd0}, no_rd, no_rd,
		chk_table, 32'h0, 32'h8008, 32'h5005}
};

// ==== test/gpr_file_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module gpr_file_tb
	import gpr_pkg::*;
;

	// one cycle of stimulus plus its check
	typedef struct packed {
		logic [2:0] tc;
		// {id, ex, wb, flush}
		logic [3:0] frz;
		gpr_wr_t wb_a;
		gpr_wr_t wb_b;
		gpr_rd_req_t rd_a;
		gpr_rd_req_t rd_b;
		gpr_rd_req_t rd_c;
		logic [1:0] chk;
		gpr_data_t exp_a;
		gpr_data_t exp_b;
		gpr_data_t exp_c;
	} row_t;

	localparam logic [1:0] chk_none = 2'd0;
	localparam logic [1:0] chk_model = 2'd1;
	localparam logic [1:0] chk_table = 2'd2;
	localparam gpr_wr_t no_wr = '0;
	localparam gpr_rd_req_t no_rd = '0;
	// ns allowed for one clock edge to show up
	localparam int edge_timeout = 100;
	localparam int n_rand = 40;

	`include "gpr_tb_table.svh"

	logic clk;
	logic rst;
	logic id_freeze;
	logic ex_freeze;
	logic wb_freeze;
	logic flushpipe;
	gpr_wr_t wb_a;
	gpr_wr_t wb_b;
	gpr_rd_req_t rd_a;
	gpr_rd_req_t rd_b;
	gpr_rd_req_t rd_c;
	gpr_data_t data_a;
	gpr_data_t data_b;
	gpr_data_t data_c;

	// reference state: registers, raw read data, hold copies
	gpr_data_t m_regs [gpr_num_regs];
	gpr_data_t m_raw [3];
	gpr_data_t m_held [3];
	logic m_valid [3];
	logic [31:0] lcg_state;

	gpr_file #(
		.zero_reg(1'b1)
	) i_gpr_file (
		.clk(clk),
		.rst(rst),
		.id_freeze(id_freeze),
		.ex_freeze(ex_freeze),
		.wb_freeze(wb_freeze),
		.flushpipe(flushpipe),
		.wb_a(wb_a),
		.wb_b(wb_b),
		.rd_a(rd_a),
		.rd_b(rd_b),
		.rd_c(rd_c),
		.data_a(data_a),
		.data_b(data_b),
		.data_c(data_c)
	);

	// 40 ns period
	always #20 clk = ~clk;

	task automatic abort_run();
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic check_val(input string name, input gpr_data_t exp, input gpr_data_t act);
		if (act !== exp) begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			abort_run();
		end
	endtask

	// one clock edge, bounded by its own polling loop
	task automatic wait_clk(input bit rising);
		bit seen;
		seen = 1'b0;
		fork
			begin
				if (rising) @(posedge clk);
				else @(negedge clk);
				seen = 1'b1;
			end
			begin
				for (int t = 0; t < edge_timeout && !seen; t++) begin
					#1;
				end
			end
		join_any
		disable fork;
		if (!seen) begin
			$display("timeout: no clock edge seen within %0d ns", edge_timeout);
			abort_run();
		end
	endtask

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic row_t random_row();
		row_t r;
		logic [31:0] v;
		logic [31:0] u;
		v = lcg_next();
		r = '0;
		r.tc = 3'd6;
		// freezes rarer than running cycles
		r.frz = {v[31:30] == 2'b00, v[29:28] == 2'b00, v[27:25] == 3'b000, v[24:22] == 3'b000};
		// addresses kept to r0..r7 so reads hit earlier writes
		r.wb_a.en = v[21];
		r.wb_a.addr = {2'b00, v[20:18]};
		r.wb_a.data = lcg_next();
		r.wb_b.en = v[17];
		r.wb_b.addr = {2'b00, v[16:14]};
		r.wb_b.data = lcg_next();
		u = lcg_next();
		r.rd_a = '{u[31], {2'b00, u[30:28]}};
		r.rd_b = '{u[27], {2'b00, u[26:24]}};
		r.rd_c = '{u[23], {2'b00, u[22:20]}};
		r.chk = chk_model;
		return r;
	endfunction

	task automatic drive_row(input row_t r);
		{id_freeze, ex_freeze, wb_freeze, flushpipe} = r.frz;
		wb_a = r.wb_a;
		wb_b = r.wb_b;
		rd_a = r.rd_a;
		rd_b = r.rd_b;
		rd_c = r.rd_c;
	endtask

	// advance the reference by one rising edge
	task automatic model_step(input row_t r);
		gpr_wr_t w;
		gpr_rd_req_t rq [3];
		logic frz [3];
		// a has priority over b
		w = r.wb_a.en ? r.wb_a : r.wb_b;
		rq[0] = r.rd_a;
		rq[1] = r.rd_b;
		rq[2] = r.rd_c;
		frz[0] = r.frz[3];
		frz[1] = r.frz[2];
		frz[2] = r.frz[2];
		for (int p = 0; p < 3; p++) begin
			// hold captures the raw word from before this edge
			if (frz[p] && !m_valid[p]) begin
				m_valid[p] = 1'b1;
				m_held[p] = m_raw[p];
			end else if (!frz[p]) begin
				m_valid[p] = 1'b0;
			end
			// decode freeze blocks reads on every port
			if (rq[p].en && !r.frz[3]) begin
				m_raw[p] = (rq[p].addr == '0) ? '0 : m_regs[rq[p].addr];
			end
		end
		// write lands after the reads, no bypass
		if (w.en && !r.frz[1] && !r.frz[0] && w.addr != '0) begin
			m_regs[w.addr] = w.data;
		end
	endtask

	function automatic gpr_data_t model_out(input int p);
		return m_valid[p] ? m_held[p] : m_raw[p];
	endfunction

	task automatic run_row(input row_t r, input int idx);
		string tag;
		drive_row(r);
		wait_clk(1'b1);
		model_step(r);
		// outputs settled well before the falling edge
		wait_clk(1'b0);
		tag = $sformatf("b%0d row %0d", r.tc, idx);
		if (r.chk == chk_table) begin
			check_val({tag, " data_a"}, r.exp_a, data_a);
			check_val({tag, " data_b"}, r.exp_b, data_b);
			check_val({tag, " data_c"}, r.exp_c, data_c);
		end else if (r.chk == chk_model) begin
			check_val({tag, " data_a"}, model_out(0), data_a);
			check_val({tag, " data_b"}, model_out(1), data_b);
			check_val({tag, " data_c"}, model_out(2), data_c);
		end
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		lcg_state = 32'd75628;
		drive_row('0);
		for (int i = 0; i < gpr_num_regs; i++) begin
			m_regs[i] = '0;
		end
		for (int p = 0; p < 3; p++) begin
			m_raw[p] = '0;
			m_held[p] = '0;
			m_valid[p] = 1'b0;
		end
		// two cycles of reset, released on a falling edge
		wait_clk(1'b1);
		wait_clk(1'b1);
		wait_clk(1'b0);
		rst = 1'b0;
		for (int i = 0; i < n_dir; i++) begin
			run_row(dir_rows[i], i);
		end
		for (int i = 0; i < n_rand; i++) begin
			run_row(random_row(), n_dir + i);
		end
		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+test
verilog/gpr_pkg.sv
verilog/gpr_wb_arbiter.sv
verilog/gpr_storage.sv
verilog/gpr_operand_hold.sv
verilog/gpr_file.sv
test/gpr_file_tb.sv
